//--- ibuf_dma_macros.svh
// shared constants for the host-to-card receive DMA
// pointers are IBUF_AW+1 bits wide, the top bit marks wrap
// completion tag is 8 bits: IBUF_TAG_BASE in the upper bits, local tag below
`ifndef IBUF_DMA_MACROS_SVH
`define IBUF_DMA_MACROS_SVH

`define IBUF_AW             9           // buffer depth 512 quadwords
`define IBUF_TAG_W          3
`define IBUF_MAX_OS         8           // equals 2**IBUF_TAG_W

// upper 5 tag bits claimed by this design
`define IBUF_TAG_BASE       5'b01010

// completion with data, fmt 2'b10 type 5'b01010
`define CPL_W_DATA_FMT_TYPE 7'b1001010
`define CPL_STATUS_SC       3'b000

`endif

//--- ibuf_dma_pkg.sv
// struct types shared by the receive DMA blocks
// rx beat layout follows the 64-bit TRN stream, first dword in [63:32]
`include "ibuf_dma_macros.svh"

package ibuf_dma_pkg;

    typedef struct packed {
        logic [63:0] data;
        logic        valid;
        logic        sof;
        logic        eof;
    } rx_beat_t;

    typedef struct packed {
        logic [63:0]            addr;   // host byte address
        logic [9:0]             qw;     // quadword count
        logic [`IBUF_TAG_W-1:0] tag;
    } rd_req_t;

    typedef struct packed {
        logic [`IBUF_TAG_W-1:0] tag;
        logic [`IBUF_AW:0]      ptr;    // buffer start, wrap bit on top
        logic [9:0]             len;    // quadwords
    } req_entry_t;

    typedef struct packed {
        logic [`IBUF_TAG_W-1:0] tag;
        logic [9:0]             len;    // dwords
    } cpl_hdr_t;

    typedef struct packed {
        logic                en;
        logic [`IBUF_AW-1:0] addr;
        logic [63:0]         data;
    } ibuf_wr_t;

endpackage

//--- rd_req_gen.sv
// splits one host buffer into memory read requests
// lbuf_en is taken in idle; after lbuf_dn the FSM waits for lbuf_en low
// a request goes out only while fill + size < depth and fewer than
// IBUF_MAX_OS requests are outstanding
`timescale 1ns/1ns
`include "ibuf_dma_macros.svh"

module rd_req_gen import ibuf_dma_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              lbuf_en,
    input  logic [63:0]       lbuf_addr,
    input  logic [31:0]       lbuf_len,
    input  logic [2:0]        cfg_max_rd_req_size,
    input  logic              rd_ack,
    input  logic [`IBUF_AW:0] committed_cons,
    input  logic              cpl_retired,
    output logic              rd,
    output rd_req_t           rd_req,
    output req_entry_t        new_req,
    output logic              new_req_valid,
    output logic              lbuf_dn
);

    typedef enum logic [2:0] {S_IDLE, S_CALC, S_SIZE, S_WAIT, S_ACK, S_DONE} state_t;

    state_t                 state;
    logic [31:0]            len_q;
    logic [31:0]            sent_q;     // quadwords already requested
    logic [31:0]            left_q;
    logic [`IBUF_AW:0]      iprod;      // producer including requests in flight
    logic [`IBUF_TAG_W:0]   os_cnt;
    logic [`IBUF_TAG_W-1:0] tag_cnt;
    logic [9:0]             mx_qw;
    logic [`IBUF_AW:0]      fill;
    logic [`IBUF_AW+1:0]    need;
    logic                   room;
    logic                   ack_hit;

    always_comb begin
        case (cfg_max_rd_req_size)
            3'd0:    mx_qw = 10'd16;
            3'd1:    mx_qw = 10'd32;
            3'd2:    mx_qw = 10'd64;
            default: mx_qw = 10'd128;
        endcase
    end

    assign fill    = iprod - committed_cons;
    assign need    = (`IBUF_AW+2)'(fill) + (`IBUF_AW+2)'(rd_req.qw);
    assign room    = need < (1 << `IBUF_AW);
    assign ack_hit = (state == S_ACK) && rd_ack;

    // outstanding count
    always_ff @(posedge clk) begin
        if (rst) begin
            os_cnt <= '0;
        end else if (ack_hit && !cpl_retired) begin
            os_cnt <= os_cnt + 1'b1;
        end else if (!ack_hit && cpl_retired) begin
            os_cnt <= os_cnt - 1'b1;
        end
    end

    ////////////////////////////////////////
    // request FSM
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= S_IDLE;
            rd            <= 1'b0;
            lbuf_dn       <= 1'b0;
            new_req_valid <= 1'b0;
            iprod         <= '0;
            tag_cnt       <= '0;
        end else begin
            lbuf_dn       <= 1'b0;
            new_req_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    rd_req.addr <= lbuf_addr;
                    len_q       <= lbuf_len;
                    sent_q      <= '0;
                    if (lbuf_en) state <= S_CALC;
                end
                S_CALC: begin
                    left_q <= len_q - sent_q;
                    state  <= S_SIZE;
                end
                S_SIZE: begin
                    rd_req.qw  <= (left_q < 32'(mx_qw)) ? left_q[9:0] : mx_qw;
                    rd_req.tag <= tag_cnt;
                    if (left_q == '0) begin     // whole buffer requested
                        lbuf_dn <= 1'b1;
                        state   <= S_DONE;
                    end else begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (room && os_cnt < `IBUF_MAX_OS) begin
                        rd    <= 1'b1;
                        state <= S_ACK;
                    end
                end
                S_ACK: begin
                    if (rd_ack) begin
                        rd            <= 1'b0;
                        rd_req.addr   <= rd_req.addr + {rd_req.qw, 3'b000};
                        sent_q        <= sent_q + rd_req.qw;
                        iprod         <= iprod + (`IBUF_AW+1)'(rd_req.qw);
                        tag_cnt       <= tag_cnt + 1'b1;
                        new_req_valid <= 1'b1;
                        new_req.tag   <= rd_req.tag;
                        new_req.ptr   <= iprod;
                        new_req.len   <= rd_req.qw;
                        state         <= S_CALC;
                    end
                end
                S_DONE: if (!lbuf_en) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- cpl_filter.sv
// picks own successful completions with data out of the rx stream
// 3DW header only; header pulse comes one cycle after the second beat
`timescale 1ns/1ns
`include "ibuf_dma_macros.svh"

module cpl_filter import ibuf_dma_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  rx_beat_t rx,
    output cpl_hdr_t cpl_hdr,
    output logic     cpl_hdr_valid
);

    typedef enum logic {F_IDLE, F_HDR2} state_t;

    state_t     state;
    logic [9:0] len_q;

    always_ff @(posedge clk) begin
        cpl_hdr.tag <= rx.data[40 +: `IBUF_TAG_W];     // DW2 tag, low bits
        cpl_hdr.len <= len_q;
        if (rst) begin
            state         <= F_IDLE;
            cpl_hdr_valid <= 1'b0;
        end else begin
            cpl_hdr_valid <= 1'b0;
            case (state)
                F_IDLE: begin
                    len_q <= rx.data[41:32];
                    if (rx.valid && rx.sof &&
                        rx.data[62:56] == `CPL_W_DATA_FMT_TYPE &&
                        rx.data[15:13] == `CPL_STATUS_SC) begin
                        state <= F_HDR2;
                    end
                end
                F_HDR2: begin
                    if (rx.valid) begin
                        // foreign tag base, drop quietly
                        if (rx.data[47:40+`IBUF_TAG_W] == `IBUF_TAG_BASE) cpl_hdr_valid <= 1'b1;
                        state <= F_IDLE;
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

endmodule

//--- cpl_writer.sv
// realigns completion dwords into quadwords and writes the buffer
// odd trailing dwords are parked per tag until the next completion
// low half of each written quadword holds the lower host address
// data beat to buffer write is two cycles
`timescale 1ns/1ns
`include "ibuf_dma_macros.svh"

module cpl_writer import ibuf_dma_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  rx_beat_t               rx,
    input  cpl_hdr_t               cpl_hdr,
    input  logic                   cpl_hdr_valid,
    input  req_entry_t             new_req,
    input  logic                   new_req_valid,
    output ibuf_wr_t               ibuf_wr,
    output logic                   cpl_done,
    output logic [`IBUF_TAG_W-1:0] cpl_done_tag,
    output logic [9:0]             cpl_done_qw
);

    // per-tag table
    logic [`IBUF_AW-1:0]    addr_tbl [`IBUF_MAX_OS];
    logic [31:0]            sdw_tbl  [`IBUF_MAX_OS];    // raw saved dword
    logic                   sv_tbl   [`IBUF_MAX_OS];

    rx_beat_t               rx_q;
    logic                   active;
    logic                   mode_q;                     // dword saved in front
    logic                   odd_q;
    logic [`IBUF_TAG_W-1:0] tag_q;
    logic [`IBUF_AW-1:0]    addr_q;
    logic [9:0]             cnt_q;
    logic [31:0]            aux_q;                      // previous low dword

    logic                   c_go, c_mode, c_odd, w_en, keep;
    logic [`IBUF_TAG_W-1:0] c_tag;
    logic [`IBUF_AW-1:0]    c_addr;
    logic [9:0]             c_cnt;
    logic [63:0]            w_data;
    logic [31:0]            keep_dw;

    function automatic logic [31:0] bswap(input logic [31:0] dw);
        return {dw[7:0], dw[15:8], dw[23:16], dw[31:24]};
    endfunction

    ////////////////////////////////////////
    // path select and realignment
    ////////////////////////////////////////
    always_comb begin
        c_go = cpl_hdr_valid || (active && rx_q.valid);
        if (cpl_hdr_valid) begin                        // rx_q is header beat 2
            c_tag  = cpl_hdr.tag;
            c_mode = sv_tbl[cpl_hdr.tag];
            c_odd  = cpl_hdr.len[0];
            c_addr = addr_tbl[cpl_hdr.tag];
            c_cnt  = '0;
        end else begin
            c_tag  = tag_q;
            c_mode = mode_q;
            c_odd  = odd_q;
            c_addr = addr_q;
            c_cnt  = cnt_q;
        end

        w_en    = 1'b1;
        keep    = 1'b0;                                 // only looked at on eof
        keep_dw = rx_q.data[31:0];
        w_data  = {bswap(rx_q.data[63:32]), bswap(aux_q)};
        if (cpl_hdr_valid) begin
            // first data dword sits in the low half
            w_en   = c_mode;
            keep   = !c_mode;
            w_data = {bswap(rx_q.data[31:0]), bswap(sdw_tbl[c_tag])};
        end else if (!c_mode) begin
            keep = c_odd;
        end else if (rx_q.eof && !c_odd) begin          // lone dword in [63:32]
            w_en    = 1'b0;
            keep    = 1'b1;
            keep_dw = rx_q.data[63:32];
        end else begin
            w_data = {bswap(rx_q.data[31:0]), bswap(rx_q.data[63:32])};
        end
    end

    always_ff @(posedge clk) begin
        rx_q         <= rx;
        ibuf_wr.addr <= c_addr;
        ibuf_wr.data <= w_data;
        cpl_done_tag <= c_tag;
        cpl_done_qw  <= c_cnt + 10'(w_en);
        if (c_go) begin
            tag_q  <= c_tag;
            mode_q <= c_mode;
            odd_q  <= c_odd;
            addr_q <= c_addr + `IBUF_AW'(w_en);
            cnt_q  <= c_cnt + 10'(w_en);
            aux_q  <= rx_q.data[31:0];
        end
        if (rst) begin
            rx_q.valid <= 1'b0;
            ibuf_wr.en <= 1'b0;
            cpl_done   <= 1'b0;
            active     <= 1'b0;
        end else begin
            ibuf_wr.en <= c_go && w_en;
            cpl_done   <= c_go && rx_q.eof;
            if (c_go) active <= !rx_q.eof;
        end
    end

    // table write back at eof, fresh entry per new request
    always_ff @(posedge clk) begin
        if (c_go && rx_q.eof) begin
            addr_tbl[c_tag] <= c_addr + `IBUF_AW'(w_en);
            sv_tbl[c_tag]   <= keep;
            sdw_tbl[c_tag]  <= keep_dw;
        end
        if (new_req_valid) begin
            addr_tbl[new_req.tag] <= new_req.ptr[`IBUF_AW-1:0];
            sv_tbl[new_req.tag]   <= 1'b0;
        end
    end

endmodule

//--- prod_commit.sv
// advances committed_prod strictly in request order
// one request retires at most every other cycle
`timescale 1ns/1ns
`include "ibuf_dma_macros.svh"

module prod_commit import ibuf_dma_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  req_entry_t             new_req,
    input  logic                   new_req_valid,
    input  logic                   cpl_done,
    input  logic [`IBUF_TAG_W-1:0] cpl_done_tag,
    input  logic [9:0]             cpl_done_qw,
    output logic [`IBUF_AW:0]      committed_prod,
    output logic                   cpl_retired
);

    logic [9:0]             len_tbl [`IBUF_MAX_OS];
    logic [9:0]             rcv_tbl [`IBUF_MAX_OS];
    logic [`IBUF_AW:0]      end_tbl [`IBUF_MAX_OS];
    logic [`IBUF_MAX_OS-1:0] pend;                      // request issued, not retired
    logic [`IBUF_TAG_W-1:0] head;                       // oldest tag
    logic [9:0]             head_rcv;
    logic                   head_done;

    // count the completion landing this cycle too
    assign head_rcv  = rcv_tbl[head] +
                       ((cpl_done && cpl_done_tag == head) ? cpl_done_qw : 10'd0);
    assign head_done = pend[head] && !cpl_retired && head_rcv == len_tbl[head];

    always_ff @(posedge clk) begin
        if (cpl_done) rcv_tbl[cpl_done_tag] <= rcv_tbl[cpl_done_tag] + cpl_done_qw;
        if (new_req_valid) begin
            rcv_tbl[new_req.tag] <= '0;
            len_tbl[new_req.tag] <= new_req.len;
            end_tbl[new_req.tag] <= new_req.ptr + (`IBUF_AW+1)'(new_req.len);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pend           <= '0;
            head           <= '0;
            committed_prod <= '0;
            cpl_retired    <= 1'b0;
        end else begin
            cpl_retired <= head_done;
            if (head_done) begin
                committed_prod <= end_tbl[head];
                pend[head]     <= 1'b0;
                head           <= head + 1'b1;
            end
            if (new_req_valid) pend[new_req.tag] <= 1'b1;
        end
    end

endmodule

//--- ibuf_dma.sv
// host-to-card DMA receive manager, top level
// rx has no back-pressure; buffer space is returned through committed_cons
`timescale 1ns/1ns
`include "ibuf_dma_macros.svh"

module ibuf_dma import ibuf_dma_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              lbuf_en,
    input  logic [63:0]       lbuf_addr,
    input  logic [31:0]       lbuf_len,
    output logic              lbuf_dn,
    input  logic [2:0]        cfg_max_rd_req_size,
    output logic              rd,
    output rd_req_t           rd_req,
    input  logic              rd_ack,
    input  rx_beat_t          rx,
    output ibuf_wr_t          ibuf_wr,
    output logic [`IBUF_AW:0] committed_prod,
    input  logic [`IBUF_AW:0] committed_cons
);

    req_entry_t             new_req;
    logic                   new_req_valid;
    cpl_hdr_t               cpl_hdr;
    logic                   cpl_hdr_valid;
    logic                   cpl_done;
    logic [`IBUF_TAG_W-1:0] cpl_done_tag;
    logic [9:0]             cpl_done_qw;
    logic                   cpl_retired;

    rd_req_gen u_rd_req_gen (
        .clk(clk), .rst(rst),
        .lbuf_en(lbuf_en), .lbuf_addr(lbuf_addr), .lbuf_len(lbuf_len),
        .cfg_max_rd_req_size(cfg_max_rd_req_size),
        .rd_ack(rd_ack), .committed_cons(committed_cons), .cpl_retired(cpl_retired),
        .rd(rd), .rd_req(rd_req),
        .new_req(new_req), .new_req_valid(new_req_valid), .lbuf_dn(lbuf_dn)
    );

    cpl_filter u_cpl_filter (
        .clk(clk), .rst(rst), .rx(rx),
        .cpl_hdr(cpl_hdr), .cpl_hdr_valid(cpl_hdr_valid)
    );

    cpl_writer u_cpl_writer (
        .clk(clk), .rst(rst), .rx(rx),
        .cpl_hdr(cpl_hdr), .cpl_hdr_valid(cpl_hdr_valid),
        .new_req(new_req), .new_req_valid(new_req_valid),
        .ibuf_wr(ibuf_wr),
        .cpl_done(cpl_done), .cpl_done_tag(cpl_done_tag), .cpl_done_qw(cpl_done_qw)
    );

    prod_commit u_prod_commit (
        .clk(clk), .rst(rst),
        .new_req(new_req), .new_req_valid(new_req_valid),
        .cpl_done(cpl_done), .cpl_done_tag(cpl_done_tag), .cpl_done_qw(cpl_done_qw),
        .committed_prod(committed_prod), .cpl_retired(cpl_retired)
    );

endmodule

//--- ibuf_dma_checker.sv
// watches the DUT ports and compares them with values built from the rules
// host dword at byte address a holds a[31:0]; buffer gets them byte swapped
// start_test and end_test are called by the testbench around each vector
`timescale 1ns/1ns
`include "ibuf_dma_macros.svh"

module ibuf_dma_checker import ibuf_dma_pkg::*; (
    input logic              clk,
    input logic              rst,
    input logic [2:0]        cfg,
    input logic              rd,
    input logic              rd_ack,
    input rd_req_t           rd_req,
    input ibuf_wr_t          ibuf_wr,
    input logic [`IBUF_AW:0] committed_prod,
    input logic [`IBUF_AW:0] committed_cons,
    input logic              lbuf_dn
);

    string                  name;
    logic [63:0]            base, exp_addr;
    int                     remaining, wr_n, wr_start, dn_cnt;
    int                     sent_n, test_first, test_len;     // quadword positions since reset
    int                     test_err, err_cnt, pass_cnt, fail_cnt;
    logic [`IBUF_AW:0]      sent, prod_q;
    logic [`IBUF_AW:0]      cum_q [$];                   // commit points still ahead
    logic [`IBUF_TAG_W-1:0] exp_tag;
    logic                   rd_q;

    initial begin
        err_cnt = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        wr_n = 0;
        sent_n = 0;
        sent = '0;
        name = "reset";
    end

    function automatic logic [31:0] swap_bytes(input logic [31:0] v);
        return {<<8{v}};
    endfunction

    function automatic int max_qw(input logic [2:0] code);
        return (code > 3) ? 128 : (16 << code);
    endfunction

    task automatic report_fail(input string what, input logic [63:0] exp, input logic [63:0] act);
        $display("FAILED %s %s expected %h actual %h", name, what, exp, act);
        test_err++;
    endtask

    task automatic start_test(input string n, input logic [63:0] addr, input int len);
        name = n;
        base = addr;
        exp_addr = addr;
        remaining = len;
        wr_start = wr_n;
        test_first = sent_n;
        test_len = len;
        dn_cnt = 0;
        test_err = 0;
    endtask

    task automatic end_test(input logic [`IBUF_AW:0] exp_prod, input int len);
        if (dn_cnt != 1) begin
            $display("FAILED %s lbuf_dn pulsed %0d times instead of once", name, dn_cnt);
            test_err++;
        end
        if (committed_prod != exp_prod) report_fail("committed_prod", exp_prod, committed_prod);
        if (wr_n - wr_start != len) report_fail("write count", len, wr_n - wr_start);
        if (remaining != 0) report_fail("quadwords not requested", 0, remaining);
        if (test_err == 0) begin
            $display("PASS test %s", name);
            pass_cnt++;
        end else begin
            $display("FAIL test %s with %0d errors", name, test_err);
            fail_cnt++;
        end
        err_cnt += test_err;
    endtask

    task automatic final_report(input int sva_err);
        $display("tests passed %0d failed %0d errors %0d assertion failures %0d",
                 pass_cnt, fail_cnt, err_cnt, sva_err);
    endtask

    always @(posedge clk) begin
        int                  q, k, d, idx;
        logic [31:0]         lo;
        logic [63:0]         exp_qw;
        logic [`IBUF_AW:0]   fill;
        logic [`IBUF_AW+1:0] need;
        if (rst) begin
            prod_q  <= '0;
            rd_q    <= 1'b0;
            exp_tag <= '0;
        end else begin
            // room must exist when rd rises
            fill = sent - committed_cons;
            need = (`IBUF_AW+2)'(fill) + (`IBUF_AW+2)'(rd_req.qw);
            if (rd && !rd_q && need >= (1 << `IBUF_AW))
                report_fail("rd raised without buffer room, need", (1 << `IBUF_AW) - 1, need);
            fill = committed_prod - committed_cons;
            if (fill > (1 << `IBUF_AW))
                report_fail("fill above depth", 1 << `IBUF_AW, fill);
            if (rd && rd_ack) begin
                q = (remaining < max_qw(cfg)) ? remaining : max_qw(cfg);
                if (rd_req.qw != q) report_fail("rd_req.qw", q, rd_req.qw);
                if (rd_req.addr != exp_addr) report_fail("rd_req.addr", exp_addr, rd_req.addr);
                if (rd_req.tag != exp_tag) report_fail("rd_req.tag", exp_tag, rd_req.tag);
                remaining -= rd_req.qw;
                exp_addr  += 8 * rd_req.qw;
                sent       = sent + (`IBUF_AW+1)'(rd_req.qw);
                sent_n    += rd_req.qw;
                cum_q.push_back(sent);
                exp_tag   <= exp_tag + 1'b1;
            end
            if (ibuf_wr.en) begin
                // requested but uncommitted span is under one depth
                d  = (sent_n - 1 - int'(ibuf_wr.addr)) & ((1 << `IBUF_AW) - 1);
                k  = sent_n - 1 - d - test_first;
                lo = base[31:0] + 32'(8 * k);
                exp_qw = {swap_bytes(lo + 32'd4), swap_bytes(lo)};
                if (k < 0 || k >= test_len) begin
                    $display("FAILED %s write to address %h outside this test's requests",
                             name, ibuf_wr.addr);
                    test_err++;
                end else if (ibuf_wr.data != exp_qw) begin
                    report_fail("ibuf_wr.data", exp_qw, ibuf_wr.data);
                end
                wr_n++;
            end
            if (committed_prod != prod_q) begin
                idx = -1;
                foreach (cum_q[j]) if (idx < 0 && cum_q[j] == committed_prod) idx = j;
                if (idx < 0) begin
                    $display("FAILED %s committed_prod moved to %h, not a request end",
                             name, committed_prod);
                    test_err++;
                end else begin
                    repeat (idx + 1) void'(cum_q.pop_front());
                end
            end
            if (lbuf_dn) dn_cnt++;
            prod_q <= committed_prod;
            rd_q   <= rd;
        end
    end

endmodule

//--- ibuf_dma_assertions.sv
// protocol properties on the read request port and lbuf_dn
// outstanding count is rebuilt from acknowledges and retirements
`timescale 1ns/1ns
`include "ibuf_dma_macros.svh"

module ibuf_dma_assertions import ibuf_dma_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     rd,
    input logic     rd_ack,
    input rd_req_t  rd_req,
    input logic     lbuf_dn,
    input logic     cpl_retired,
    input ibuf_wr_t ibuf_wr
);

    int os;
    int err_cnt;    // failed assertions

    initial err_cnt = 0;

    always_ff @(posedge clk) begin
        if (rst) os <= 0;
        else os <= os + int'(rd && rd_ack) - int'(cpl_retired);
    end

    a_rd_hold: assert property (@(posedge clk) disable iff (rst)
        rd && !rd_ack |=> rd && $stable(rd_req))
        else begin
            $error("rd or rd_req changed before rd_ack");
            err_cnt++;
        end

    a_os_limit: assert property (@(posedge clk) disable iff (rst) os <= `IBUF_MAX_OS)
        else begin
            $error("more than IBUF_MAX_OS requests outstanding");
            err_cnt++;
        end

    a_dn_pulse: assert property (@(posedge clk) disable iff (rst) lbuf_dn |=> !lbuf_dn)
        else begin
            $error("lbuf_dn longer than one cycle");
            err_cnt++;
        end

    a_wr_known: assert property (@(posedge clk) disable iff (rst)
        ibuf_wr.en |-> !$isunknown(ibuf_wr.addr))
        else begin
            $error("buffer write with unknown address");
            err_cnt++;
        end

endmodule

bind ibuf_dma ibuf_dma_assertions u_ibuf_dma_assertions (
    .clk(clk), .rst(rst), .rd(rd), .rd_ack(rd_ack), .rd_req(rd_req),
    .lbuf_dn(lbuf_dn), .cpl_retired(cpl_retired), .ibuf_wr(ibuf_wr)
);

//--- ibuf_dma_tb.sv
// testbench for the receive DMA; vectors come from ibuf_dma_vectors.txt
// host model answers reads with completions, plus two foreign ones each
// committed_cons is frozen for a while at test start, then lags prod
`timescale 1ns/1ns
`include "ibuf_dma_macros.svh"

module ibuf_dma_tb import ibuf_dma_pkg::*;;

    logic              clk, rst, lbuf_en, lbuf_dn, rd, rd_ack;
    logic [63:0]       lbuf_addr;
    logic [31:0]       lbuf_len;
    logic [2:0]        cfg;
    rd_req_t           rd_req, ack_req;
    rx_beat_t          rx;
    ibuf_wr_t          ibuf_wr;
    logic [`IBUF_AW:0] committed_prod, committed_cons;
    logic [`IBUF_AW:0] lag [8];

    rd_req_t     pend_q [$];
    string       t_name [$];
    logic [63:0] t_addr [$];
    int          t_len [$], t_max [$], t_split [$], t_order [$];
    int          seed, wait_cnt, hold_cnt, split_mode, order_mode, busy, total;

    ibuf_dma u_ibuf_dma (
        .clk(clk), .rst(rst), .lbuf_en(lbuf_en), .lbuf_addr(lbuf_addr),
        .lbuf_len(lbuf_len), .lbuf_dn(lbuf_dn), .cfg_max_rd_req_size(cfg),
        .rd(rd), .rd_req(rd_req), .rd_ack(rd_ack), .rx(rx), .ibuf_wr(ibuf_wr),
        .committed_prod(committed_prod), .committed_cons(committed_cons)
    );

    ibuf_dma_checker u_checker (
        .clk(clk), .rst(rst), .cfg(cfg), .rd(rd), .rd_ack(rd_ack), .rd_req(rd_req),
        .ibuf_wr(ibuf_wr), .committed_prod(committed_prod),
        .committed_cons(committed_cons), .lbuf_dn(lbuf_dn)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////
    // host memory model
    ////////////////////////////////////////
    task automatic send_beat(input logic [63:0] d, input logic sof, input logic eof);
        @(posedge clk);
        #2;
        rx.data  = d;
        rx.valid = 1'b1;
        rx.sof   = sof;
        rx.eof   = eof;
    endtask

    // 3DW completion header, n dwords starting at byte address a0
    task automatic send_cpl(input logic [2:0] tag, input logic [4:0] tbase,
                            input logic [2:0] status, input logic [31:0] a0, input int n);
        logic [31:0] a;
        int          i;
        a = a0;
        send_beat({1'b0, `CPL_W_DATA_FMT_TYPE, 14'd0, 10'(n),
                   16'h0001, status, 1'b0, 12'(4 * n)}, 1'b1, 1'b0);
        send_beat({16'h0100, tbase, tag, 1'b0, a[6:0], a}, 1'b0, n == 1);
        a = a + 32'd4;
        i = 1;
        while (i < n) begin
            send_beat({a, (i + 1 < n) ? a + 32'd4 : 32'd0}, 1'b0, i + 2 >= n);
            a = a + 32'd8;
            i = i + 2;
        end
        @(posedge clk);
        #2;
        rx = '0;
    endtask

    task automatic answer_req(input rd_req_t r);
        int n_dw, k;
        n_dw = 2 * r.qw;
        k = r.qw[0] ? r.qw : r.qw - 1;          // odd first part
        send_cpl(r.tag, 5'b10101, `CPL_STATUS_SC, r.addr[31:0], 4);
        send_cpl(r.tag, `IBUF_TAG_BASE, 3'b001, r.addr[31:0], 4);
        if (split_mode != 0) begin
            send_cpl(r.tag, `IBUF_TAG_BASE, `CPL_STATUS_SC, r.addr[31:0], k);
            send_cpl(r.tag, `IBUF_TAG_BASE, `CPL_STATUS_SC, r.addr[31:0] + 32'(4 * k),
                     n_dw - k);
        end else begin
            send_cpl(r.tag, `IBUF_TAG_BASE, `CPL_STATUS_SC, r.addr[31:0], n_dw);
        end
    endtask

    // acknowledge after a random delay
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (rd_ack) begin
                rd_ack = 1'b0;
                pend_q.push_back(ack_req);
            end else if (rd) begin
                if (wait_cnt == 0) begin
                    rd_ack   = 1'b1;
                    ack_req  = rd_req;
                    wait_cnt = $random(seed) & 7;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    // completion sender, swaps adjacent pairs in order mode 1
    initial begin
        rd_req_t a, b;
        int      idle, last_size;
        idle = 0;
        last_size = 0;
        forever begin
            @(posedge clk);
            #2;
            idle = (pend_q.size() != last_size) ? 0 : idle + 1;
            if (order_mode != 0 && pend_q.size() >= 2) begin
                busy = 1;
                a = pend_q.pop_front();
                b = pend_q.pop_front();
                answer_req(b);
                answer_req(a);
            end else if (pend_q.size() >= 1 && (order_mode == 0 || idle > 20)) begin
                busy = 1;
                a = pend_q.pop_front();
                answer_req(a);
            end
            busy = 0;
            last_size = pend_q.size();
        end
    end

    // consumer pointer, frozen during hold then lagging prod
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (hold_cnt > 0) hold_cnt--;
            else committed_cons = lag[7];
            for (int i = 7; i > 0; i--) lag[i] = lag[i - 1];
            lag[0] = committed_prod;
        end
    end

    ////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////
    initial begin
        int          fd, lim, n, len, mx, sp, od;
        string       line, nm;
        logic [63:0] addr;
        seed = 32'h2898;
        rst = 1'b1;
        lbuf_en = 1'b0;
        lbuf_addr = '0;
        lbuf_len = '0;
        cfg = '0;
        rd_ack = 1'b0;
        rx = '0;
        committed_cons = '0;
        foreach (lag[i]) lag[i] = '0;
        wait_cnt = 0;
        hold_cnt = 0;
        split_mode = 0;
        order_mode = 0;
        busy = 0;
        total = 0;
        lim = 0;
        fd = $fopen("ibuf_dma_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open ibuf_dma_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%s %h %d %d %d %d", nm, addr, len, mx, sp, od);
                if (n == 6 && nm.getc(0) != "#") begin
                    t_name.push_back(nm);
                    t_addr.push_back(addr);
                    t_len.push_back(len);
                    t_max.push_back(mx);
                    t_split.push_back(sp);
                    t_order.push_back(od);
                    lim += len * 40;
                end
            end
            $fclose(fd);
        end
        fork
            begin
                repeat (lim + 1000 * t_len.size() + 2000) @(posedge clk);
                $display("watchdog expired before all tests finished");
                $display("Done: errors found");
                $finish;
            end
        join_none
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (t_len[i]) begin
            @(posedge clk);
            #1;
            cfg = 3'(t_max[i]);
            lbuf_addr = t_addr[i];
            lbuf_len = t_len[i];
            split_mode = t_split[i];
            order_mode = t_order[i];
            hold_cnt = 300;
            u_checker.start_test(t_name[i], t_addr[i], t_len[i]);
            lbuf_en = 1'b1;
            while (!lbuf_dn) begin
                @(posedge clk);
                #1;
            end
            lbuf_en = 1'b0;
            while (pend_q.size() > 0 || busy != 0 || rd_ack) begin
                @(posedge clk);
                #1;
            end
            total += t_len[i];
            for (int w = 0; w < 400 && committed_prod != (`IBUF_AW+1)'(total); w++)
                @(posedge clk);
            repeat (4) @(posedge clk);
            #1;
            u_checker.end_test((`IBUF_AW+1)'(total), t_len[i]);
        end
        u_checker.final_report(u_ibuf_dma.u_ibuf_dma_assertions.err_cnt);
        if (u_checker.err_cnt == 0 && t_len.size() > 0 &&
            u_ibuf_dma.u_ibuf_dma_assertions.err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- ibuf_dma_vectors.txt
# name  host_addr(hex)  len_qw(dec)  max_rd_code  split(1=two cpls)  order(1=swap pairs)
basic_16          0000000100000000   16  0 0 0
split_odd         0000000100001000   40  0 1 0
max32_swap        00000002000a0000  130  1 0 1
max64_split_swap  0000000300100008  300  2 1 1
max128_long       0000000400200000  700  3 0 0
bp_long_mix       0000000500300010 1000  3 1 1
tiny_5            0000000600400000    5  1 1 0
code7_swap        0000000700500000   64  7 0 1

//--- ibuf_dma.f
+incdir+.
ibuf_dma_pkg.sv
rd_req_gen.sv
cpl_filter.sv
cpl_writer.sv
prod_commit.sv
ibuf_dma.sv
ibuf_dma_checker.sv
ibuf_dma_assertions.sv
ibuf_dma_tb.sv

//--- Bender.yml
package:
  name: ibuf_dma

export_include_dirs:
  - .

sources:
  - ibuf_dma_pkg.sv
  - rd_req_gen.sv
  - cpl_filter.sv
  - cpl_writer.sv
  - prod_commit.sv
  - ibuf_dma.sv
  - target: test
    files:
      - ibuf_dma_checker.sv
      - ibuf_dma_assertions.sv
      - ibuf_dma_tb.sv
